// ==== source/board_ctrl_pkg.sv ====
// board_ctrl_pkg: register map, widths, tick divisors and shared types of the board controller.
`default_nettype none

package board_ctrl_pkg;

	////////////////////
	// basic types
	////////////////////

	// register bus address and data.
	typedef logic [4:0] csr_addr_t;
	typedef logic [7:0] csr_data_t;

	// one register bus cycle, write strobe in the lsb.
	typedef struct packed {
		csr_addr_t addr;
		csr_data_t wdata;
		logic      we;
	} csr_req_t;

	// interrupt sources: wdt, sleep, power_btn, smb_alert, rtc (bit 0).
	typedef logic [4:0] irq_vec_t;

	// board inputs, active low as on the pins.
	// charger_prsnt_n, charging_n, batlow_n, lid_n, sleep_n, power_btn_n (bit 0).
	typedef logic [5:0] gpi_vec_t;

	// watchdog timeout and down-counter.
	typedef logic [7:0] wdt_count_t;

	typedef enum logic [1:0] {
		WDT_IDLE,
		WDT_RUN,
		WDT_FIRE
	} wdt_state_t;

	////////////////////
	// register map
	////////////////////

	localparam csr_data_t CPLD_VERSION = 8'h21;

	localparam csr_addr_t ADDR_VERSION     = 5'h00;
	localparam csr_addr_t ADDR_GPI         = 5'h01;
	localparam csr_addr_t ADDR_WDT_CTRL    = 5'h04;
	localparam csr_addr_t ADDR_WDT_TIMEOUT = 5'h05;
	localparam csr_addr_t ADDR_WDT_KICK    = 5'h06;
	localparam csr_addr_t ADDR_WDT_COUNT   = 5'h07;
	localparam csr_addr_t ADDR_PWM_CTRL    = 5'h0C;
	localparam csr_addr_t ADDR_PWM_DUTY    = 5'h0D;
	localparam csr_addr_t ADDR_IRQ_ENABLE  = 5'h1C;
	localparam csr_addr_t ADDR_IRQ_PENDING = 5'h1D;

	localparam wdt_count_t WDT_DEFAULT_TIMEOUT = 8'd8;

	// clocks per fast tick, fast ticks per slow tick.
	localparam int FAST_DIV = 4;
	localparam int SLOW_DIV = 64;

	localparam int FAST_CNT_W = $clog2(FAST_DIV);
	localparam int SLOW_CNT_W = $clog2(SLOW_DIV);

endpackage

`default_nettype wire

// ==== source/tick_gen.sv ====
// tick_gen: divides clk into a fast and a slow one-clock enable strobe.
`default_nettype none

module tick_gen (
	input  wire  clk,
	input  wire  rst,
	output logic tick_fast,
	output logic tick_slow
);

	import board_ctrl_pkg::*;

	logic [FAST_CNT_W-1:0] fast_cnt;
	logic [SLOW_CNT_W-1:0] slow_cnt;
	logic                  fast_wrap;
	logic                  slow_wrap;

	assign fast_wrap = (fast_cnt == FAST_CNT_W'(FAST_DIV - 1));
	assign slow_wrap = (slow_cnt == SLOW_CNT_W'(SLOW_DIV - 1));

	// both counters restart at reset, so the tick phase is known.
	always_ff @(posedge clk) begin
		if (rst) begin
			fast_cnt  <= '0;
			slow_cnt  <= '0;
			tick_fast <= 1'b0;
			tick_slow <= 1'b0;
		end else begin
			tick_fast <= fast_wrap;
			// slow tick lands on the same clock as its fast tick.
			tick_slow <= fast_wrap & slow_wrap;
			if (fast_wrap) begin
				fast_cnt <= '0;
				if (slow_wrap) begin
					slow_cnt <= '0;
				end else begin
					slow_cnt <= slow_cnt + 1'b1;
				end
			end else begin
				fast_cnt <= fast_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/input_sync.sv ====
// input_sync: synchronizes the active-low board inputs and strobes their edges.
`default_nettype none

module input_sync (
	input  wire                       clk,
	input  wire                       rst,
	input  wire board_ctrl_pkg::gpi_vec_t pins_n,
	input  wire                       rtc_int_n,
	input  wire                       smb_alert_n,
	output board_ctrl_pkg::gpi_vec_t  levels,
	output logic                      rtc_fall,
	output logic                      smb_fall,
	output logic                      btn_edge,
	output logic                      sleep_fall
);

	import board_ctrl_pkg::*;

	// smb_alert_n, rtc_int_n, then the gpi pins.
	logic [7:0] meta;
	logic [7:0] sync;
	// previous value of the edge-sensed inputs: smb, rtc, sleep, button.
	logic [3:0] prev;
	logic [3:0] cur;

	assign cur = {sync[7], sync[6], sync[1], sync[0]};

	// idle level is high on every pin.
	always_ff @(posedge clk) begin
		if (rst) begin
			meta <= '1;
			sync <= '1;
			prev <= '1;
		end else begin
			meta <= {smb_alert_n, rtc_int_n, pins_n};
			sync <= meta;
			prev <= cur;
		end
	end

	// strobes are registered, one clock after the sync stage settles.
	always_ff @(posedge clk) begin
		if (rst) begin
			btn_edge   <= 1'b0;
			sleep_fall <= 1'b0;
			rtc_fall   <= 1'b0;
			smb_fall   <= 1'b0;
		end else begin
			// button press and release both count.
			btn_edge   <= cur[0] ^ prev[0];
			sleep_fall <= prev[1] & ~cur[1];
			rtc_fall   <= prev[2] & ~cur[2];
			smb_fall   <= prev[3] & ~cur[3];
		end
	end

	assign levels = sync[5:0];

endmodule

`default_nettype wire

// ==== source/irq_ctrl.sv ====
// irq_ctrl: interrupt enable and pending registers driving the combined interrupt line.
`default_nettype none

module irq_ctrl (
	input  wire                           clk,
	input  wire                           rst,
	input  wire board_ctrl_pkg::csr_req_t csr,
	input  wire board_ctrl_pkg::irq_vec_t sources,
	output board_ctrl_pkg::csr_data_t     rdata,
	output logic                          irq
);

	import board_ctrl_pkg::*;

	irq_vec_t enable;
	irq_vec_t pending;
	irq_vec_t clear;
	logic     wr_enable;
	logic     wr_pending;

	assign wr_enable  = csr.we && (csr.addr == ADDR_IRQ_ENABLE);
	assign wr_pending = csr.we && (csr.addr == ADDR_IRQ_PENDING);

	// write one to clear.
	assign clear = wr_pending ? irq_vec_t'(csr.wdata) : '0;

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= '0;
		end else if (wr_enable) begin
			enable <= irq_vec_t'(csr.wdata);
		end
	end

	// a new source strobe beats a clear in the same clock.
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clear) | sources;
		end
	end

	////////////////////
	// readback
	////////////////////

	always_comb begin
		rdata = '0;
		if (csr.addr == ADDR_IRQ_ENABLE) begin
			rdata = csr_data_t'(enable);
		end else if (csr.addr == ADDR_IRQ_PENDING) begin
			rdata = csr_data_t'(pending);
		end
	end

	// masked pending bits.
	assign irq = |(pending & enable);

endmodule

`default_nettype wire

// ==== source/watchdog.sv ====
// watchdog: programmable timeout counter that strobes a cpu reset and an interrupt on expiry.
`default_nettype none

module watchdog (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           tick,
	input  wire board_ctrl_pkg::csr_req_t csr,
	output board_ctrl_pkg::csr_data_t     rdata,
	output logic                          cpu_reset,
	output logic                          wdt_irq
);

	import board_ctrl_pkg::*;

	wdt_state_t state;
	wdt_count_t timeout;
	wdt_count_t count;
	logic       wr_ctrl;
	logic       wr_timeout;
	logic       wr_kick;
	logic       running;

	assign wr_ctrl    = csr.we && (csr.addr == ADDR_WDT_CTRL);
	assign wr_timeout = csr.we && (csr.addr == ADDR_WDT_TIMEOUT);
	assign wr_kick    = csr.we && (csr.addr == ADDR_WDT_KICK);

	// the enable bit is the running state itself.
	assign running = (state == WDT_RUN);

	always_ff @(posedge clk) begin
		if (rst) begin
			timeout <= WDT_DEFAULT_TIMEOUT;
		end else if (wr_timeout) begin
			timeout <= csr.wdata;
		end
	end

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WDT_IDLE;
			count <= '0;
		end else begin
			unique case (state)
				WDT_IDLE: begin
					if ((wr_ctrl && csr.wdata[0]) || wr_kick) begin
						count <= timeout;
					end
					if (wr_ctrl && csr.wdata[0]) begin
						state <= WDT_RUN;
					end
				end
				WDT_RUN: begin
					if (wr_ctrl && !csr.wdata[0]) begin
						state <= WDT_IDLE;
					end else if (wr_ctrl || wr_kick) begin
						count <= timeout;
					end else if (count == '0) begin
						// expired, fire for exactly one clock.
						state <= WDT_FIRE;
					end else if (tick) begin
						count <= count - 1'b1;
					end
				end
				WDT_FIRE: begin
					state <= WDT_IDLE;
				end
				default: begin
					state <= WDT_IDLE;
				end
			endcase
		end
	end

	assign cpu_reset = (state == WDT_FIRE);
	assign wdt_irq   = (state == WDT_FIRE);

	// kick register is write only.
	always_comb begin
		unique case (csr.addr)
			ADDR_WDT_CTRL:    rdata = csr_data_t'(running);
			ADDR_WDT_TIMEOUT: rdata = timeout;
			ADDR_WDT_COUNT:   rdata = count;
			default:          rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/pwm.sv ====
// pwm: 8-bit PWM generator with enable and duty registers.
`default_nettype none

module pwm (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           tick,
	input  wire board_ctrl_pkg::csr_req_t csr,
	output board_ctrl_pkg::csr_data_t     rdata,
	output logic                          pwm_out
);

	import board_ctrl_pkg::*;

	logic      enable;
	csr_data_t duty;
	logic [7:0] cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			enable <= 1'b0;
			duty   <= '0;
		end else if (csr.we) begin
			if (csr.addr == ADDR_PWM_CTRL) begin
				enable <= csr.wdata[0];
			end
			if (csr.addr == ADDR_PWM_DUTY) begin
				duty <= csr.wdata;
			end
		end
	end

	// period counter, parked at zero while disabled.
	// wraps from 255 back to 0 on its own.
	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			cnt <= '0;
		end else if (tick) begin
			cnt <= cnt + 1'b1;
		end
	end

	assign pwm_out = enable && (cnt < duty);

	always_comb begin
		rdata = '0;
		if (csr.addr == ADDR_PWM_CTRL) begin
			rdata = csr_data_t'(enable);
		end else if (csr.addr == ADDR_PWM_DUTY) begin
			rdata = duty;
		end
	end

endmodule

`default_nettype wire

// ==== source/board_ctrl_top.sv ====
// board_ctrl_top: board management register block with watchdog, interrupts and PWM.
`default_nettype none

module board_ctrl_top (
	input  wire                           clk,
	input  wire                           rst,
	input  wire board_ctrl_pkg::csr_req_t csr,
	output board_ctrl_pkg::csr_data_t     rdata,
	input  wire board_ctrl_pkg::gpi_vec_t pins_n,
	input  wire                           rtc_int_n,
	input  wire                           smb_alert_n,
	output logic                          irq,
	output logic                          cpu_reset,
	output logic                          pwm_out
);

	import board_ctrl_pkg::*;

	logic      tick_fast;
	logic      tick_slow;
	gpi_vec_t  levels;
	logic      rtc_fall;
	logic      smb_fall;
	logic      btn_edge;
	logic      sleep_fall;
	logic      wdt_irq;
	irq_vec_t  sources;
	csr_data_t rdata_local;
	csr_data_t rdata_irq;
	csr_data_t rdata_wdt;
	csr_data_t rdata_pwm;

	tick_gen i_tick_gen (
		.clk       (clk),
		.rst       (rst),
		.tick_fast (tick_fast),
		.tick_slow (tick_slow)
	);

	input_sync i_input_sync (
		.clk         (clk),
		.rst         (rst),
		.pins_n      (pins_n),
		.rtc_int_n   (rtc_int_n),
		.smb_alert_n (smb_alert_n),
		.levels      (levels),
		.rtc_fall    (rtc_fall),
		.smb_fall    (smb_fall),
		.btn_edge    (btn_edge),
		.sleep_fall  (sleep_fall)
	);

	// rtc in bit 0 up to the watchdog in bit 4.
	assign sources = {wdt_irq, sleep_fall, btn_edge, smb_fall, rtc_fall};

	irq_ctrl i_irq_ctrl (
		.clk     (clk),
		.rst     (rst),
		.csr     (csr),
		.sources (sources),
		.rdata   (rdata_irq),
		.irq     (irq)
	);

	watchdog i_watchdog (
		.clk       (clk),
		.rst       (rst),
		.tick      (tick_slow),
		.csr       (csr),
		.rdata     (rdata_wdt),
		.cpu_reset (cpu_reset),
		.wdt_irq   (wdt_irq)
	);

	pwm i_pwm (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick_fast),
		.csr     (csr),
		.rdata   (rdata_pwm),
		.pwm_out (pwm_out)
	);

	////////////////////
	// read path
	////////////////////

	always_comb begin
		unique case (csr.addr)
			ADDR_VERSION: rdata_local = CPLD_VERSION;
			ADDR_GPI:     rdata_local = csr_data_t'(levels);
			default:      rdata_local = '0;
		endcase
	end

	// unaddressed blocks return zero, so a plain OR selects.
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
		end else begin
			rdata <= rdata_local | rdata_irq | rdata_wdt | rdata_pwm;
		end
	end

endmodule

`default_nettype wire

// ==== bench/board_ctrl_assertions.sv ====
// board_ctrl_assertions: bound checks on the watchdog strobes and the interrupt line.
`default_nettype none

module board_ctrl_assertions (
	input wire                             clk,
	input wire                             rst,
	input wire                             cpu_reset,
	input wire                             wdt_irq,
	input wire board_ctrl_pkg::wdt_count_t count,
	input wire                             irq,
	input wire board_ctrl_pkg::irq_vec_t   pending,
	input wire board_ctrl_pkg::irq_vec_t   enable,
	input wire board_ctrl_pkg::irq_vec_t   sources
);

	cpu_reset_one_clock: assert property (
		@(posedge clk) disable iff (rst) cpu_reset |=> !cpu_reset
	) else $error("cpu_reset stayed high for more than one clock");

	// both strobes only once the count has run out.
	wdt_irq_with_reset: assert property (
		@(posedge clk) disable iff (rst)
		(wdt_irq || cpu_reset) |-> (wdt_irq && cpu_reset && count == '0)
	) else $error("wdt_irq and cpu_reset do not pulse together on expiry");

	// an enabled bit was pending or strobed one clock earlier.
	irq_has_source: assert property (
		@(posedge clk) disable iff (rst)
		irq |-> |(enable & ($past(pending) | $past(sources)))
	) else $error("irq is high without a pending and enabled bit");

endmodule

// the watchdog carries the strobes and irq_ctrl the interrupt line.
bind watchdog board_ctrl_assertions i_wdt_assertions (
	.clk       (clk),
	.rst       (rst),
	.cpu_reset (cpu_reset),
	.wdt_irq   (wdt_irq),
	.count     (count),
	.irq       (1'b0),
	.pending   (5'h00),
	.enable    (5'h00),
	.sources   (5'h00)
);

bind irq_ctrl board_ctrl_assertions i_irq_assertions (
	.clk       (clk),
	.rst       (rst),
	.cpu_reset (1'b0),
	.wdt_irq   (1'b0),
	.count     (8'h00),
	.irq       (irq),
	.pending   (pending),
	.enable    (enable),
	.sources   (sources)
);

`default_nettype wire

// ==== bench/board_ctrl_tb.sv ====
// board_ctrl_tb: directed testbench for the board management register block.
`default_nettype none

module board_ctrl_tb;

	import board_ctrl_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CLOCKS = 4;
	localparam int SLOW_PERIOD  = FAST_DIV * SLOW_DIV;
	localparam int PWM_PERIOD   = 256 * FAST_DIV;
	localparam int KICKS        = 6;
	localparam int GPI_PATTERNS = 8;
	localparam logic [15:0] LFSR_SEED = 16'd31;
	// rough clock budget of all tests plus half again as margin.
	localparam int TEST_CLOCKS = RESET_CLOCKS + 64 + GPI_PATTERNS * 16 + 160
		+ (KICKS + 4) * SLOW_PERIOD + 3 * (PWM_PERIOD + 48);
	localparam int LIMIT_CLOCKS = TEST_CLOCKS + TEST_CLOCKS / 2;

	logic        clk;
	logic        rst;
	csr_req_t    csr;
	csr_data_t   rdata;
	gpi_vec_t    pins_n;
	logic        rtc_int_n;
	logic        smb_alert_n;
	logic        irq;
	logic        cpu_reset;
	logic        pwm_out;
	logic [15:0] lfsr_state;
	int          mismatch_count;
	int          failure_count;
	int          reset_pulses;

	board_ctrl_top i_board_ctrl_top (
		.clk         (clk),
		.rst         (rst),
		.csr         (csr),
		.rdata       (rdata),
		.pins_n      (pins_n),
		.rtc_int_n   (rtc_int_n),
		.smb_alert_n (smb_alert_n),
		.irq         (irq),
		.cpu_reset   (cpu_reset),
		.pwm_out     (pwm_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// counted on the falling edge away from the state update.
	always @(negedge clk) begin
		if (rst) begin
			reset_pulses <= 0;
		end else if (cpu_reset) begin
			reset_pulses <= reset_pulses + 1;
		end
	end

	////////////////////
	// helpers
	////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken.
	task automatic random_bits(input int n, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[6:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic check_data(input string name, input csr_data_t actual, input csr_data_t expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: got 0x%02h, expected 0x%02h", name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	task automatic write_reg(input csr_addr_t addr, input csr_data_t data);
		@(posedge clk);
		#2;
		csr.addr  = addr;
		csr.wdata = data;
		csr.we    = 1'b1;
		@(posedge clk);
		#2;
		csr.we = 1'b0;
	endtask

	// rdata is registered and shows the address one clock later.
	task automatic read_reg(input csr_addr_t addr, output csr_data_t data);
		@(posedge clk);
		#2;
		csr.addr = addr;
		csr.we   = 1'b0;
		@(posedge clk);
		#1;
		data = rdata;
	endtask

	task automatic expect_reg(input string name, input csr_addr_t addr, input csr_data_t expected);
		csr_data_t value;
		read_reg(addr, value);
		check_data(name, value, expected);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic reset_values();
		check_data("rdata", rdata, 8'h00);
		check_bit("irq", irq, 1'b0);
		check_bit("pwm_out", pwm_out, 1'b0);
		check_bit("cpu_reset", cpu_reset, 1'b0);
		expect_reg("version", ADDR_VERSION, CPLD_VERSION);
		expect_reg("wdt timeout", ADDR_WDT_TIMEOUT, WDT_DEFAULT_TIMEOUT);
		expect_reg("wdt ctrl", ADDR_WDT_CTRL, 8'h00);
		expect_reg("pwm ctrl", ADDR_PWM_CTRL, 8'h00);
		expect_reg("pwm duty", ADDR_PWM_DUTY, 8'h00);
		expect_reg("irq enable", ADDR_IRQ_ENABLE, 8'h00);
		expect_reg("irq pending", ADDR_IRQ_PENDING, 8'h00);
	endtask

	task automatic gpi_readback();
		logic [7:0] pattern;
		for (int i = 0; i < GPI_PATTERNS; i++) begin
			random_bits(6, pattern);
			@(posedge clk);
			#2;
			pins_n = pattern[5:0];
			wait_clocks(4);
			expect_reg("gpi", ADDR_GPI, {2'b00, pattern[5:0]});
		end
		@(posedge clk);
		#2;
		pins_n = '1;
		wait_clocks(6);
	endtask

	task automatic rtc_and_button_irq();
		write_reg(ADDR_IRQ_ENABLE, 8'h00);
		write_reg(ADDR_IRQ_PENDING, 8'h1F);
		expect_reg("irq pending", ADDR_IRQ_PENDING, 8'h00);
		// low long enough to pass the synchronizer.
		@(posedge clk);
		#2;
		rtc_int_n = 1'b0;
		wait_clocks(2);
		#2;
		rtc_int_n = 1'b1;
		wait_clocks(6);
		expect_reg("irq pending", ADDR_IRQ_PENDING, 8'h01);
		check_bit("irq", irq, 1'b0);
		write_reg(ADDR_IRQ_ENABLE, 8'h01);
		check_bit("irq", irq, 1'b1);
		write_reg(ADDR_IRQ_PENDING, 8'h01);
		check_bit("irq", irq, 1'b0);
		expect_reg("irq pending", ADDR_IRQ_PENDING, 8'h00);
		// press and release of the power button.
		@(posedge clk);
		#2;
		pins_n[0] = 1'b0;
		wait_clocks(6);
		#2;
		pins_n[0] = 1'b1;
		wait_clocks(6);
		expect_reg("irq pending", ADDR_IRQ_PENDING, 8'h04);
		write_reg(ADDR_IRQ_PENDING, 8'h04);
		write_reg(ADDR_IRQ_ENABLE, 8'h00);
	endtask

	task automatic watchdog_expiry();
		int start;
		int waited;
		write_reg(ADDR_WDT_TIMEOUT, 8'h02);
		write_reg(ADDR_WDT_CTRL, 8'h01);
		expect_reg("wdt ctrl", ADDR_WDT_CTRL, 8'h01);
		start = reset_pulses;
		// kicks come slightly faster than the slow tick so the count never drains.
		for (int k = 0; k < KICKS; k++) begin
			wait_clocks(SLOW_PERIOD - 8);
			write_reg(ADDR_WDT_KICK, 8'h00);
		end
		check_data("cpu_reset pulses", csr_data_t'(reset_pulses - start), 8'h00);
		waited = 0;
		while (reset_pulses == start && waited < 3 * SLOW_PERIOD) begin
			@(posedge clk);
			waited++;
		end
		if (reset_pulses == start) begin
			failure_count++;
			$display("cpu_reset did not pulse within 3 slow-tick periods after the last kick");
		end
		wait_clocks(4);
		check_data("cpu_reset pulses", csr_data_t'(reset_pulses - start), 8'h01);
		expect_reg("irq pending", ADDR_IRQ_PENDING, 8'h10);
		expect_reg("wdt ctrl", ADDR_WDT_CTRL, 8'h00);
		write_reg(ADDR_IRQ_PENDING, 8'h10);
		write_reg(ADDR_WDT_TIMEOUT, WDT_DEFAULT_TIMEOUT);
	endtask

	task automatic measure_pwm(input csr_data_t duty);
		int high;
		write_reg(ADDR_PWM_DUTY, duty);
		write_reg(ADDR_PWM_CTRL, 8'h01);
		expect_reg("pwm duty", ADDR_PWM_DUTY, duty);
		high = 0;
		for (int i = 0; i < PWM_PERIOD; i++) begin
			@(posedge clk);
			#1;
			if (pwm_out) begin
				high++;
			end
		end
		// a full period of high time would wrap the tick count to zero.
		check_bit("pwm_out low within period", high < PWM_PERIOD, 1'b1);
		// one fast tick of high time per duty step.
		check_bit("pwm_out high on tick boundary", (high % FAST_DIV) == 0, 1'b1);
		check_data("pwm_out high ticks", csr_data_t'(high / FAST_DIV), duty);
		write_reg(ADDR_PWM_CTRL, 8'h00);
		check_bit("pwm_out", pwm_out, 1'b0);
	endtask

	task automatic pwm_duty_cycle();
		measure_pwm(8'd0);
		measure_pwm(8'd64);
		measure_pwm(8'd255);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		rst            = 1'b1;
		csr            = '0;
		pins_n         = '1;
		rtc_int_n      = 1'b1;
		smb_alert_n    = 1'b1;
		lfsr_state     = LFSR_SEED;
		mismatch_count = 0;
		failure_count  = 0;
		wait_clocks(RESET_CLOCKS);
		#2;
		rst = 1'b0;
		reset_values();
		gpi_readback();
		rtc_and_button_irq();
		watchdog_expiry();
		pwm_duty_cycle();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count + failure_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CLOCKS * CLK_PERIOD);
		$display("timeout: tests still running after %0d clocks", LIMIT_CLOCKS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/board_ctrl_pkg.sv
source/tick_gen.sv
source/input_sync.sv
source/irq_ctrl.sv
source/watchdog.sv
source/pwm.sv
source/board_ctrl_top.sv
bench/board_ctrl_assertions.sv
bench/board_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the board_ctrl testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module board_ctrl_tb -Mdir obj_dir -f vlog.f

./obj_dir/Vboard_ctrl_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
